/* tb.f */
rtl/cpu_pkg.sv
rtl/pipe_if.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/execute_unit.sv
rtl/irq_ctrl.sv
rtl/cpu_top.sv
bench/tb_model.sv
bench/tb_cpu.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_cpu
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    // Both interrupts with the waits around them
    localparam int IRQ_CYCLES   = 200;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 6 * tb_model::LOOP_ADDR + IRQ_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic        irq;
    logic        hold;
    logic        store_en;
    logic [31:0] store_addr;
    logic [31:0] store_data;

    logic        hold_en;
    int          n_stores;
    logic        prev_hold;
    logic        prev_en;
    logic [31:0] prev_addr;
    logic [31:0] prev_data;

    cpu_top #(
        .RESET_PC   (32'h0),
        .IRQ_VECTOR (32'(tb_model::IRQ_VECTOR))
    ) DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .irq        (irq),
        .hold       (hold),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    // Instruction memory answers without delay
    assign imem_data = tb_model::prog[imem_addr[8:0]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic wait_stores(input int target);
        while (n_stores < target) begin
            @(posedge clk);
        end
    endtask

    // Pulse irq in the cycle after the loop branch redirects
    task automatic pulse_irq_in_loop(input logic nested);
        @(negedge clk);
        while (imem_addr !== tb_model::LOOP_ADDR + 2) begin
            @(negedge clk);
        end
        @(posedge clk);
        irq <= 1'b1;
        @(posedge clk);
        irq <= 1'b0;
        // Fetch jumps to the handler right after acceptance
        @(negedge clk);
        check_word("imem_addr", imem_addr, 32'(tb_model::IRQ_VECTOR));
        if (nested) begin
            // Handler is running, so this one must be ignored
            @(posedge clk);
            irq <= 1'b1;
            @(posedge clk);
            irq <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (hold_en) begin
            hold <= (tb_model::rnd(3) == 0);
        end else begin
            hold <= 1'b0;
        end
    end

    // Store port monitor for the transfer at the next rising edge
    always @(negedge clk) begin
        logic [63:0] exp_st;
        if (rst_n) begin
            if (prev_hold) begin
                check_word("store_en", {31'd0, store_en}, {31'd0, prev_en});
                check_word("store_addr", store_addr, prev_addr);
                check_word("store_data", store_data, prev_data);
            end
            if (store_en && !hold) begin
                assert (tb_model::exp_q.size() != 0) else begin
                    stop_on_error("Store transfer seen while none was expected");
                end
                exp_st = tb_model::exp_q.pop_front();
                check_word("store_addr", store_addr, exp_st[63:32]);
                check_word("store_data", store_data, exp_st[31:0]);
                n_stores = n_stores + 1;
            end
        end
        prev_hold = hold;
        prev_en   = store_en;
        prev_addr = store_addr;
        prev_data = store_data;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_error("Timeout while waiting for the expected store transfers");
    end

    initial begin
        int n_prog;
        rst_n     = 1'b0;
        irq       = 1'b0;
        hold      = 1'b0;
        hold_en   = 1'b0;
        n_stores  = 0;
        prev_hold = 1'b0;
        prev_en   = 1'b0;
        prev_addr = '0;
        prev_data = '0;
        tb_model::build_program();
        tb_model::run_model();
        n_prog = tb_model::exp_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n   <= 1'b1;
        hold_en <= 1'b1;
        @(negedge clk);
        check_word("store_en", {31'd0, store_en}, 32'd0);
        check_word("imem_addr", imem_addr, 32'h0);
        // Program phase under random hold
        wait_stores(n_prog);
        @(posedge clk);
        hold_en <= 1'b0;
        repeat (10) @(posedge clk);
        // First interrupt plus a nested pulse give one marker in total
        tb_model::exp_q.push_back({tb_model::MARK_ADDR, tb_model::MARK_DATA});
        pulse_irq_in_loop(1'b1);
        wait_stores(n_prog + 1);
        repeat (20) @(posedge clk);
        // After RTI the latch is clear again
        tb_model::exp_q.push_back({tb_model::MARK_ADDR, tb_model::MARK_DATA});
        pulse_irq_in_loop(1'b0);
        wait_stores(n_prog + 2);
        repeat (30) @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

/* bench/tb_model.sv */
package tb_model;

    localparam int MEM_WORDS  = 512;
    localparam int INIT_REGS  = 7;
    localparam int BODY_LEN   = 60;
    // Final self-loop sits right after the random body
    localparam int LOOP_ADDR  = INIT_REGS + BODY_LEN;
    localparam int IRQ_VECTOR = 'h100;

    // Transfer written by the interrupt handler
    localparam logic [31:0] MARK_ADDR = 32'h7ff;
    localparam logic [31:0] MARK_DATA = 32'h5a5;

    integer      seed = 32'h9514_86ba;
    logic [31:0] prog [MEM_WORDS];
    // Expected transfers, address in the upper half
    logic [63:0] exp_q [$];

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] enc_r(input cpu_pkg::opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        cpu_pkg::instr_u w;
        w.r.opcode = op;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        w.r.unused = '0;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input cpu_pkg::opcode_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [17:0] imm);
        cpu_pkg::instr_u w;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic void place_word(input int addr, input logic [31:0] word);
        prog[9'(addr)] = word;
    endfunction

    function automatic void build_program();
        int          a;
        int          off;
        logic [4:0]  rd;
        logic [4:0]  src;
        logic [4:0]  last_rd;
        logic [17:0] imm;
        // NOP fill that still differs at every address
        for (int i = 0; i < MEM_WORDS; i++) begin
            place_word(i, {cpu_pkg::OP_NOP, 28'(i)});
        end
        for (int r = 1; r <= INIT_REGS; r++) begin
            place_word(r - 1, enc_i(cpu_pkg::OP_ADDI, 5'(r), 5'd0, 18'(rnd(1 << 18))));
        end
        last_rd = 5'(INIT_REGS);
        for (int k = 0; k < BODY_LEN; k++) begin
            a   = INIT_REGS + k;
            rd  = 5'(rnd(8));
            imm = 18'(rnd(1 << 18));
            // Mostly read the register written just before
            src = (rnd(4) != 0) ? last_rd : 5'(rnd(8));
            case (rnd(9))
                0, 1, 2, 3: begin
                    place_word(a, enc_r(cpu_pkg::opcode_e'(4'(rnd(6))), rd, src, 5'(rnd(8))));
                    last_rd = rd;
                end
                4: begin
                    place_word(a, enc_i(cpu_pkg::OP_ADDI, rd, src, imm));
                    last_rd = rd;
                end
                5, 6: begin
                    place_word(a, enc_i(cpu_pkg::OP_STORE, src, 5'(rnd(8)), imm));
                end
                7: begin
                    // Forward only, never past the loop
                    off = 2 + rnd(3);
                    if (a + off > LOOP_ADDR) begin
                        off = LOOP_ADDR - a;
                    end
                    place_word(a, enc_i((rnd(2) != 0) ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BNE,
                                        rd, src, 18'(off)));
                end
                default: begin
                    place_word(a, enc_i(cpu_pkg::OP_NOP, 5'd0, 5'd0, 18'd0));
                end
            endcase
        end
        place_word(LOOP_ADDR, enc_i(cpu_pkg::OP_BEQ, 5'd0, 5'd0, 18'd0));
        place_word(LOOP_ADDR + 1, enc_i(cpu_pkg::OP_BNE, 5'd0, 5'd0, -18'sd1));
        // Handler writes the marker through r9 and returns
        place_word(IRQ_VECTOR, enc_i(cpu_pkg::OP_ADDI, 5'd9, 5'd0, MARK_DATA[17:0]));
        place_word(IRQ_VECTOR + 1, enc_i(cpu_pkg::OP_STORE, 5'd9, 5'd0, MARK_ADDR[17:0]));
        place_word(IRQ_VECTOR + 2, enc_i(cpu_pkg::OP_RTI, 5'd0, 5'd0, 18'd0));
    endfunction

    function automatic void run_model();
        logic [31:0]     regs [32];
        logic [31:0]     pc;
        logic [31:0]     npc;
        logic [31:0]     imm;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     res;
        logic            wr;
        cpu_pkg::instr_u w;
        int              steps;
        for (int r = 0; r < 32; r++) begin
            regs[5'(r)] = '0;
        end
        exp_q.delete();
        pc    = '0;
        steps = 0;
        while (pc != LOOP_ADDR && steps < MEM_WORDS) begin
            w   = prog[pc[8:0]];
            a   = regs[w.r.rs1];
            b   = regs[w.r.rs2];
            // Branch operand and store data both come from rd
            c   = regs[w.i.rd];
            imm = {{14{w.i.imm[17]}}, w.i.imm};
            npc = pc + 32'd1;
            wr  = 1'b1;
            res = '0;
            case (w.r.opcode)
                cpu_pkg::OP_ADD:  res = a + b;
                cpu_pkg::OP_SUB:  res = a - b;
                cpu_pkg::OP_AND:  res = a & b;
                cpu_pkg::OP_OR:   res = a | b;
                cpu_pkg::OP_XOR:  res = a ^ b;
                cpu_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                cpu_pkg::OP_ADDI: res = a + imm;
                default:          wr = 1'b0;
            endcase
            if (wr && w.r.rd != 5'd0) begin
                regs[w.r.rd] = res;
            end
            if (w.r.opcode == cpu_pkg::OP_STORE) begin
                exp_q.push_back({a + imm, c});
            end
            if ((w.r.opcode == cpu_pkg::OP_BEQ && a == c) ||
                (w.r.opcode == cpu_pkg::OP_BNE && a != c)) begin
                npc = pc + imm;
            end
            pc    = npc;
            steps = steps + 1;
        end
    endfunction

endpackage

/* rtl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
    parameter logic [31:0] RESET_PC   = 32'h0,
    parameter logic [31:0] IRQ_VECTOR = 32'h100
) (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_data,
    input  logic        irq,
    input  logic        hold,
    output logic        store_en,
    output logic [31:0] store_addr,
    output logic [31:0] store_data
);

    logic        stall;
    logic        flush;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        rti_done;
    logic        irq_take;
    logic [31:0] fd_instr;
    logic [31:0] fd_pc;
    logic        fd_valid;
    logic [31:0] dec_pc;
    logic        dec_valid;
    logic [31:0] epc;
    logic        wb_en;
    logic [4:0]  wb_reg;
    logic [31:0] wb_data;

    pipe_if pipe ();

    assign stall = hold;
    // Both a redirect and an accepted interrupt drop the younger stages
    assign flush = redirect || irq_take;

    fetch_unit #(
        .RESET_PC   (RESET_PC),
        .IRQ_VECTOR (IRQ_VECTOR)
    ) u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .irq_take    (irq_take),
        .dec_pc      (dec_pc),
        .dec_valid   (dec_valid),
        .imem_data   (imem_data),
        .imem_addr   (imem_addr),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .fd_valid    (fd_valid),
        .epc         (epc)
    );

    decode_unit u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .flush     (flush),
        .fd_instr  (fd_instr),
        .fd_pc     (fd_pc),
        .fd_valid  (fd_valid),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .epc       (epc),
        .dec_pc    (dec_pc),
        .dec_valid (dec_valid),
        .pipe      (pipe.dec)
    );

    execute_unit u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .pipe        (pipe.exe),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .rti_done    (rti_done),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .store_en    (store_en),
        .store_addr  (store_addr),
        .store_data  (store_data)
    );

    irq_ctrl u_irq (
        .clk      (clk),
        .rst_n    (rst_n),
        .irq      (irq),
        .hold     (hold),
        .redirect (redirect),
        .rti_done (rti_done),
        .irq_take (irq_take)
    );

endmodule

/* rtl/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic irq,
    input  logic hold,
    input  logic redirect,
    input  logic rti_done,
    output logic irq_take
);

    // Set while a handler runs, blocks nested interrupts
    logic in_handler;

    // A pending redirect owns the PC this cycle, so the request waits
    assign irq_take = irq && !in_handler && !hold && !redirect;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_handler <= 1'b0;
        end else if (rti_done) begin
            in_handler <= 1'b0;
        end else if (irq_take) begin
            in_handler <= 1'b1;
        end
    end

endmodule

/* rtl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    pipe_if.exe         pipe,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output logic        rti_done,
    output logic        wb_en,
    output logic [4:0]  wb_reg,
    output logic [31:0] wb_data,
    output logic        store_en,
    output logic [31:0] store_addr,
    output logic [31:0] store_data
);

    logic [31:0] alu_out;
    logic        operands_eq;
    logic        taken;
    logic        fire;

    always_comb begin
        case (pipe.op)
            cpu_pkg::ALU_SUB: alu_out = pipe.opa - pipe.opb;
            cpu_pkg::ALU_AND: alu_out = pipe.opa & pipe.opb;
            cpu_pkg::ALU_OR:  alu_out = pipe.opa | pipe.opb;
            cpu_pkg::ALU_XOR: alu_out = pipe.opa ^ pipe.opb;
            cpu_pkg::ALU_SLT: alu_out = {31'd0, $signed(pipe.opa) < $signed(pipe.opb)};
            default:          alu_out = pipe.opa + pipe.opb;
        endcase
    end

    // Instruction in execute takes effect this cycle
    assign fire = pipe.valid && !stall;

    assign wb_en   = pipe.valid && pipe.reg_wr;
    assign wb_reg  = pipe.dst;
    assign wb_data = alu_out;

    assign operands_eq = (pipe.opa == pipe.opb);
    assign taken       = pipe.is_branch && (pipe.branch_ne ? !operands_eq : operands_eq);

    // RTI carries the saved return address in imm
    assign redirect    = fire && (taken || pipe.is_rti);
    assign redirect_pc = pipe.is_rti ? pipe.imm : pipe.pc + pipe.imm;
    assign rti_done    = fire && pipe.is_rti;

    // Store port, held while stalled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            store_en <= 1'b0;
        end else if (!stall) begin
            store_en <= pipe.valid && pipe.is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && pipe.is_store) begin
            store_addr <= pipe.opa + pipe.imm;
            store_data <= pipe.store_data;
        end
    end

endmodule

/* rtl/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        flush,
    input  logic [31:0] fd_instr,
    input  logic [31:0] fd_pc,
    input  logic        fd_valid,
    input  logic        wb_en,
    input  logic [4:0]  wb_reg,
    input  logic [31:0] wb_data,
    input  logic [31:0] epc,
    output logic [31:0] dec_pc,
    output logic        dec_valid,
    pipe_if.dec         pipe
);

    cpu_pkg::instr_u  ins;
    cpu_pkg::alu_op_e op;
    logic             is_r;
    logic             uses_imm;
    logic             writes_rd;
    logic             is_branch;
    logic             branch_ne;
    logic             is_store;
    logic             is_rti;
    logic [4:0]       rb;
    logic [31:0]      imm_ext;
    logic [31:0]      ra_val;
    logic [31:0]      rb_val;
    logic [31:0]      rf [32];

    assign ins       = fd_instr;
    assign dec_pc    = fd_pc;
    assign dec_valid = fd_valid;

    always_comb begin
        op        = cpu_pkg::ALU_ADD;
        is_r      = 1'b0;
        uses_imm  = 1'b0;
        writes_rd = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        is_store  = 1'b0;
        is_rti    = 1'b0;
        case (ins.r.opcode)
            cpu_pkg::OP_ADD:   begin is_r = 1'b1; writes_rd = 1'b1; end
            cpu_pkg::OP_SUB:   begin is_r = 1'b1; writes_rd = 1'b1; op = cpu_pkg::ALU_SUB; end
            cpu_pkg::OP_AND:   begin is_r = 1'b1; writes_rd = 1'b1; op = cpu_pkg::ALU_AND; end
            cpu_pkg::OP_OR:    begin is_r = 1'b1; writes_rd = 1'b1; op = cpu_pkg::ALU_OR;  end
            cpu_pkg::OP_XOR:   begin is_r = 1'b1; writes_rd = 1'b1; op = cpu_pkg::ALU_XOR; end
            cpu_pkg::OP_SLT:   begin is_r = 1'b1; writes_rd = 1'b1; op = cpu_pkg::ALU_SLT; end
            cpu_pkg::OP_ADDI:  begin uses_imm = 1'b1; writes_rd = 1'b1; end
            cpu_pkg::OP_BEQ:   is_branch = 1'b1;
            cpu_pkg::OP_BNE:   begin is_branch = 1'b1; branch_ne = 1'b1; end
            cpu_pkg::OP_STORE: is_store = 1'b1;
            cpu_pkg::OP_RTI:   is_rti = 1'b1;
            default:           ;
        endcase
    end

    // Second read port: rs2 in R-format, rd otherwise (branch operand, store data)
    assign rb      = is_r ? ins.r.rs2 : ins.i.rd;
    assign imm_ext = {{14{ins.i.imm[17]}}, ins.i.imm};

    // Bypass the result that execute writes back this cycle
    assign ra_val = (ins.r.rs1 == 5'd0) ? 32'd0 :
                    (wb_en && wb_reg == ins.r.rs1) ? wb_data : rf[ins.r.rs1];
    assign rb_val = (rb == 5'd0) ? 32'd0 :
                    (wb_en && wb_reg == rb) ? wb_data : rf[rb];

    always_ff @(posedge clk) begin
        if (wb_en && !stall) begin
            rf[wb_reg] <= wb_data;
        end
    end

    // Decode/execute stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pipe.valid <= 1'b0;
        end else if (!stall) begin
            pipe.valid <= fd_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pipe.op         <= op;
            pipe.opa        <= ra_val;
            pipe.opb        <= uses_imm ? imm_ext : rb_val;
            pipe.store_data <= rb_val;
            pipe.dst        <= ins.r.rd;
            // Writes to r0 are dropped here
            pipe.reg_wr     <= writes_rd && (ins.r.rd != 5'd0);
            pipe.is_branch  <= is_branch;
            pipe.branch_ne  <= branch_ne;
            pipe.is_store   <= is_store;
            pipe.is_rti     <= is_rti;
            pipe.pc         <= fd_pc;
            pipe.imm        <= is_rti ? epc : imm_ext;
        end
    end

endmodule

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] RESET_PC   = 32'h0,
    parameter logic [31:0] IRQ_VECTOR = 32'h100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        irq_take,
    input  logic [31:0] dec_pc,
    input  logic        dec_valid,
    input  logic [31:0] imem_data,
    output logic [31:0] imem_addr,
    output logic [31:0] fd_instr,
    output logic [31:0] fd_pc,
    output logic        fd_valid,
    output logic [31:0] epc
);

    logic [31:0] pc;
    logic [31:0] pc_next;

    assign imem_addr = pc;

    // Redirect from execute wins over a new interrupt
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (irq_take) begin
            pc_next = IRQ_VECTOR;
        end else begin
            pc_next = pc + 32'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    // Return address is the oldest instruction that gets discarded
    always_ff @(posedge clk) begin
        if (!stall && irq_take) begin
            epc <= dec_valid ? dec_pc : pc;
        end
    end

    // Fetch/decode stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fd_valid <= 1'b0;
        end else if (!stall) begin
            fd_valid <= !(redirect || irq_take);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_instr <= imem_data;
            fd_pc    <= pc;
        end
    end

endmodule

/* rtl/pipe_if.sv */
`timescale 1ns/1ps

// Decoded operation passed from decode to execute
interface pipe_if;
    logic               valid;
    cpu_pkg::alu_op_e   op;
    logic [31:0]        opa;
    logic [31:0]        opb;
    logic [31:0]        store_data;
    logic [4:0]         dst;
    logic               reg_wr;
    logic               is_branch;
    // Set for BNE, clear for BEQ
    logic               branch_ne;
    logic               is_store;
    logic               is_rti;
    logic [31:0]        pc;
    logic [31:0]        imm;

    modport dec (
        output valid, op, opa, opb, store_data, dst, reg_wr,
        output is_branch, branch_ne, is_store, is_rti, pc, imm
    );

    modport exe (
        input valid, op, opa, opb, store_data, dst, reg_wr,
        input is_branch, branch_ne, is_store, is_rti, pc, imm
    );

endinterface

/* rtl/cpu_pkg.sv */
package cpu_pkg;

    // Instruction opcodes, codes 12 to 15 decode as NOP
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLT   = 4'd5,
        OP_ADDI  = 4'd6,
        OP_BEQ   = 4'd7,
        OP_BNE   = 4'd8,
        OP_STORE = 4'd9,
        OP_RTI   = 4'd10,
        OP_NOP   = 4'd11
    } opcode_e;

    // Register format for the three-operand ALU instructions
    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [12:0] unused;
    } r_fmt_t;

    // Immediate format
    // BEQ/BNE compare rs1 with rd, STORE writes rd to rs1 + imm
    typedef struct packed {
        opcode_e            opcode;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic signed [17:0] imm;
    } i_fmt_t;

    // One fetched word, seen through either format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // Operations carried out by the execute stage ALU
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

endpackage
